// File: pma_unit.f
+incdir+design
design/pma_pkg.sv
design/pma_region_regs.sv
design/pma_match.sv
design/pma_checker.sv
design/pma_event_monitor.sv
design/pma_unit.sv
test/pma_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the PMA unit testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f pma_unit.f --top-module pma_unit_tb -o pma_sim \
  && ./obj_dir/pma_sim | tee /dev/stderr | grep -qx "sim passed" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// File: test/pma_unit_tb.sv
// Directed testbench for the PMA unit, checking responses and counters against a small model
`timescale 1ns/1ns
`include "pma_defines.svh"

module pma_unit_tb;

  import pma_pkg::*;

  localparam int CLK_PERIOD = 8;
  // Generous bound over the length of the directed tests
  localparam int MAX_CYCLES = 2000;
  localparam int EV_NUM     = 5;

  logic       clk_ungated;
  logic       rst_n;
  logic       cfg_we_i;
  pma_idx_t   cfg_region_i;
  pma_field_e cfg_field_i;
  pma_addr_t  cfg_wdata_i;
  pma_addr_t  cfg_rdata_o;
  logic       trans_valid_i;
  pma_addr_t  trans_addr_i;
  pma_kind_e  trans_kind_i;
  pma_size_e  trans_size_i;
  logic       resp_valid_o;
  logic       resp_allow_o;
  pma_attr_t  resp_attr_o;
  logic       resp_have_match_o;
  pma_idx_t   resp_match_idx_o;
  logic       resp_misaligned_o;
  pma_event_e mon_sel_i;
  logic       mon_clr_i;
  pma_cnt_t   mon_count_o;

  // Reference model state
  pma_addr_t m_base  [`PMA_NUM_REGIONS];
  pma_addr_t m_limit [`PMA_NUM_REGIONS];
  pma_attr_t m_attr  [`PMA_NUM_REGIONS];
  pma_cnt_t  tally   [EV_NUM];
  logic      exp_allow;
  logic      exp_have;
  logic      exp_mis;
  pma_attr_t exp_attr;
  pma_idx_t  exp_idx;

  integer     seed;
  int         cycles;
  pma_kind_e  kinds [3] = '{LOAD, STORE, EXEC};
  pma_size_e  sizes [3] = '{BYTE, HALF, WORD};
  pma_event_e evs [EV_NUM] = '{ACCESS, MULTI, MISALIGN, DENY, IO};

  pma_unit DUT (
    .clk_ungated       (clk_ungated),
    .rst_n             (rst_n),
    .cfg_we_i          (cfg_we_i),
    .cfg_region_i      (cfg_region_i),
    .cfg_field_i       (cfg_field_i),
    .cfg_wdata_i       (cfg_wdata_i),
    .cfg_rdata_o       (cfg_rdata_o),
    .trans_valid_i     (trans_valid_i),
    .trans_addr_i      (trans_addr_i),
    .trans_kind_i      (trans_kind_i),
    .trans_size_i      (trans_size_i),
    .resp_valid_o      (resp_valid_o),
    .resp_allow_o      (resp_allow_o),
    .resp_attr_o       (resp_attr_o),
    .resp_have_match_o (resp_have_match_o),
    .resp_match_idx_o  (resp_match_idx_o),
    .resp_misaligned_o (resp_misaligned_o),
    .mon_sel_i         (mon_sel_i),
    .mon_clr_i         (mon_clr_i),
    .mon_count_o       (mon_count_o)
  );

  initial begin
    clk_ungated = 1'b0;
    forever #(CLK_PERIOD / 2) clk_ungated = ~clk_ungated;
  end

  always @(posedge clk_ungated) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the tests did not finish", cycles);
      $display("sim failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic fail_stop();
    $display("sim failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      fail_stop();
    end
  endtask

  task automatic check_attr(input string name, input pma_attr_t got, input pma_attr_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      fail_stop();
    end
  endtask

  task automatic check_idx(input string name, input pma_idx_t got, input pma_idx_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      fail_stop();
    end
  endtask

  task automatic check_cnt(input string name, input pma_cnt_t got, input pma_cnt_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      fail_stop();
    end
  endtask

  task automatic check_addr(input string name, input pma_addr_t got, input pma_addr_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
      fail_stop();
    end
  endtask

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic void count_event(input pma_event_e ev, input logic hit);
    if (hit && tally[ev] != '1) begin
      tally[ev] = tally[ev] + pma_cnt_t'(1);
    end
  endfunction

  // Every task starts and ends 1 ns after a rising edge
  task automatic cfg_write(input pma_idx_t r, input pma_field_e f, input pma_addr_t d);
    cfg_we_i     = 1'b1;
    cfg_region_i = r;
    cfg_field_i  = f;
    cfg_wdata_i  = d;
    case (f)
      BASE:    m_base[r] = d;
      LIMIT:   m_limit[r] = d;
      default: m_attr[r] = d[2:0];
    endcase
    @(posedge clk_ungated);
    #1;
    cfg_we_i = 1'b0;
  endtask

  task automatic set_region(input pma_idx_t r, input pma_addr_t b, input pma_addr_t l,
                            input pma_attr_t a);
    cfg_write(r, BASE, b);
    cfg_write(r, LIMIT, l);
    cfg_write(r, ATTR, pma_addr_t'(a));
  endtask

  task automatic read_field(input pma_idx_t r, input pma_field_e f, input pma_addr_t exp);
    cfg_region_i = r;
    cfg_field_i  = f;
    #2;
    check_addr("cfg_rdata_o", cfg_rdata_o, exp);
    @(posedge clk_ungated);
    #1;
  endtask

  // Computes the expected response from the region and allow rules, then strobes
  task automatic drive_access(input pma_addr_t addr, input pma_kind_e kind, input pma_size_e size);
    int hits;
    hits     = 0;
    exp_have = 1'b0;
    exp_idx  = '0;
    exp_attr = '0;
    for (int r = 0; r < `PMA_NUM_REGIONS; r++) begin
      if (m_base[r] <= addr && addr < m_limit[r]) begin
        hits++;
        if (!exp_have) begin
          exp_have = 1'b1;
          exp_idx  = pma_idx_t'(r);
          exp_attr = m_attr[r];
        end
      end
    end
    exp_mis = (size == HALF && addr % 2 != 0) || (size == WORD && addr % 4 != 0);
    if (!exp_have) begin
      exp_allow = 1'b0;
    end else if (kind == EXEC) begin
      exp_allow = exp_attr[2] && !exp_mis;
    end else begin
      exp_allow = exp_attr[2] || !exp_mis;
    end
    count_event(ACCESS, 1'b1);
    count_event(MULTI, hits >= 2);
    count_event(MISALIGN, exp_mis);
    count_event(DENY, !exp_allow);
    count_event(IO, exp_have && !exp_attr[2]);
    trans_valid_i = 1'b1;
    trans_addr_i  = addr;
    trans_kind_i  = kind;
    trans_size_i  = size;
  endtask

  task automatic check_response();
    if (resp_valid_o !== 1'b1) begin
      $display("No response valid one cycle after the access strobe");
      fail_stop();
    end
    check_bit("resp_allow_o", resp_allow_o, exp_allow);
    check_bit("resp_have_match_o", resp_have_match_o, exp_have);
    check_bit("resp_misaligned_o", resp_misaligned_o, exp_mis);
    check_attr("resp_attr_o", resp_attr_o, exp_attr);
    check_idx("resp_match_idx_o", resp_match_idx_o, exp_idx);
  endtask

  task automatic access_check(input pma_addr_t addr, input pma_kind_e kind, input pma_size_e size);
    drive_access(addr, kind, size);
    @(posedge clk_ungated);
    #1;
    trans_valid_i = 1'b0;
    check_response();
  endtask

  task automatic check_counters();
    for (int e = 0; e < EV_NUM; e++) begin
      mon_sel_i = evs[e];
      #2;
      check_cnt($sformatf("mon_count_o[%s]", evs[e].name()), mon_count_o, tally[evs[e]]);
      @(posedge clk_ungated);
      #1;
    end
  endtask

  task automatic clear_monitor();
    mon_clr_i = 1'b1;
    @(posedge clk_ungated);
    #1;
    mon_clr_i = 1'b0;
    for (int e = 0; e < EV_NUM; e++) begin
      tally[e] = '0;
    end
  endtask

  task automatic test_reset_readback();
    pma_addr_t wd;
    for (int r = 0; r < `PMA_NUM_REGIONS; r++) begin
      read_field(pma_idx_t'(r), BASE, '0);
      read_field(pma_idx_t'(r), LIMIT, '0);
      read_field(pma_idx_t'(r), ATTR, '0);
    end
    access_check(32'h0000_0100, LOAD, WORD);
    check_bit("resp_have_match_o", resp_have_match_o, 1'b0);
    check_bit("resp_allow_o", resp_allow_o, 1'b0);
    for (int r = 0; r < `PMA_NUM_REGIONS; r++) begin
      wd = 32'h1000_0000 * (r + 1) + 32'h40;
      cfg_write(pma_idx_t'(r), BASE, wd);
      cfg_write(pma_idx_t'(r), LIMIT, wd + 32'h800);
      cfg_write(pma_idx_t'(r), ATTR, 32'ha5a5_a5a8 | (r + 4));
    end
    for (int r = 0; r < `PMA_NUM_REGIONS; r++) begin
      wd = 32'h1000_0000 * (r + 1) + 32'h40;
      read_field(pma_idx_t'(r), BASE, wd);
      read_field(pma_idx_t'(r), LIMIT, wd + 32'h800);
      read_field(pma_idx_t'(r), ATTR, (32'ha5a5_a5a8 | (r + 4)) & 32'h7);
    end
  endtask

  task automatic test_match_priority();
    pma_addr_t edges [12] = '{32'h0100, 32'h01ff, 32'h0200, 32'h1000, 32'h17ff, 32'h1800,
                              32'h1fff, 32'h2000, 32'h2fff, 32'h3000, 32'h5000, 32'h0000};
    // Region 0 stands alone, regions 1 and 2 overlap, region 3 is empty
    set_region(0, 32'h0100, 32'h0200, 3'b111);
    set_region(1, 32'h1000, 32'h2000, 3'b100);
    set_region(2, 32'h1800, 32'h3000, 3'b011);
    set_region(3, 32'h5000, 32'h5000, 3'b101);
    foreach (edges[i]) begin
      access_check(edges[i], LOAD, BYTE);
    end
    for (int i = 0; i < 40; i++) begin
      access_check(pma_addr_t'($random(seed)) & 32'h0000_3fff,
                   kinds[rand_below(3)], sizes[rand_below(3)]);
    end
  endtask

  task automatic test_allow_rule();
    pma_addr_t bases [2] = '{32'h0100, 32'h1000};
    set_region(0, 32'h0100, 32'h0200, 3'b100);
    set_region(1, 32'h1000, 32'h2000, 3'b011);
    set_region(2, 32'h0000, 32'h0000, 3'b000);
    set_region(3, 32'h0000, 32'h0000, 3'b000);
    foreach (bases[b]) begin
      foreach (kinds[k]) begin
        foreach (sizes[s]) begin
          for (int off = 0; off < 4; off++) begin
            access_check(bases[b] + off, kinds[k], sizes[s]);
          end
        end
      end
    end
    // Fixed anchors for the I/O and fetch cases
    access_check(32'h1000, LOAD, WORD);
    check_bit("resp_allow_o", resp_allow_o, 1'b1);
    access_check(32'h1001, STORE, HALF);
    check_bit("resp_allow_o", resp_allow_o, 1'b0);
    access_check(32'h1000, EXEC, WORD);
    check_bit("resp_allow_o", resp_allow_o, 1'b0);
    access_check(32'h0102, EXEC, WORD);
    check_bit("resp_allow_o", resp_allow_o, 1'b0);
    access_check(32'h0100, EXEC, WORD);
    check_bit("resp_allow_o", resp_allow_o, 1'b1);
  endtask

  task automatic test_back_to_back();
    for (int i = 0; i < 16; i++) begin
      drive_access(pma_addr_t'($random(seed)) & 32'h0000_1fff,
                   kinds[rand_below(3)], sizes[rand_below(3)]);
      @(posedge clk_ungated);
      #1;
      check_response();
    end
    trans_valid_i = 1'b0;
    @(posedge clk_ungated);
    #1;
    check_bit("resp_valid_o", resp_valid_o, 1'b0);
  endtask

  task automatic test_event_monitor();
    set_region(2, 32'h1800, 32'h2800, 3'b100);
    clear_monitor();
    access_check(32'h1900, LOAD, WORD);
    access_check(32'h0101, LOAD, HALF);
    access_check(32'h1001, STORE, HALF);
    access_check(32'h4000, LOAD, BYTE);
    access_check(32'h0100, EXEC, WORD);
    access_check(32'h2400, EXEC, BYTE);
    access_check(32'h1c02, STORE, WORD);
    check_counters();
    clear_monitor();
    check_counters();
    // Clear and strobe together leave every count at zero
    mon_clr_i = 1'b1;
    drive_access(32'h1900, EXEC, WORD);
    @(posedge clk_ungated);
    #1;
    mon_clr_i     = 1'b0;
    trans_valid_i = 1'b0;
    check_response();
    for (int e = 0; e < EV_NUM; e++) begin
      tally[e] = '0;
    end
    check_counters();
  endtask

  task automatic test_write_then_access();
    set_region(0, 32'h0100, 32'h0200, 3'b100);
    access_check(32'h0200, LOAD, WORD);
    check_bit("resp_have_match_o", resp_have_match_o, 1'b0);
    cfg_write(0, LIMIT, 32'h0300);
    access_check(32'h0200, LOAD, WORD);
    check_bit("resp_have_match_o", resp_have_match_o, 1'b1);
  endtask

  initial begin
    seed          = 32'h26b1;
    cycles        = 0;
    rst_n         = 1'b0;
    cfg_we_i      = 1'b0;
    cfg_region_i  = '0;
    cfg_field_i   = BASE;
    cfg_wdata_i   = '0;
    trans_valid_i = 1'b0;
    trans_addr_i  = '0;
    trans_kind_i  = LOAD;
    trans_size_i  = BYTE;
    mon_sel_i     = ACCESS;
    mon_clr_i     = 1'b0;
    for (int r = 0; r < `PMA_NUM_REGIONS; r++) begin
      m_base[r]  = '0;
      m_limit[r] = '0;
      m_attr[r]  = '0;
    end
    for (int e = 0; e < EV_NUM; e++) begin
      tally[e] = '0;
    end
    repeat (8) @(posedge clk_ungated);
    #1;
    rst_n = 1'b1;
    test_reset_readback();
    test_match_priority();
    test_allow_rule();
    test_back_to_back();
    test_event_monitor();
    test_write_then_access();
    $display("sim passed");
    $finish;
  end

endmodule

// File: design/pma_unit.sv
// Top of the PMA checking unit for one bus side, wiring config, match, check and monitor
`timescale 1ns/1ns
`include "pma_defines.svh"

module pma_unit (
  input  logic                clk_ungated,
  input  logic                rst_n,
  input  logic                cfg_we_i,
  input  pma_pkg::pma_idx_t   cfg_region_i,
  input  pma_pkg::pma_field_e cfg_field_i,
  input  pma_pkg::pma_addr_t  cfg_wdata_i,
  output pma_pkg::pma_addr_t  cfg_rdata_o,
  input  logic                trans_valid_i,
  input  pma_pkg::pma_addr_t  trans_addr_i,
  input  pma_pkg::pma_kind_e  trans_kind_i,
  input  pma_pkg::pma_size_e  trans_size_i,
  output logic                resp_valid_o,
  output logic                resp_allow_o,
  output pma_pkg::pma_attr_t  resp_attr_o,
  output logic                resp_have_match_o,
  output pma_pkg::pma_idx_t   resp_match_idx_o,
  output logic                resp_misaligned_o,
  input  pma_pkg::pma_event_e mon_sel_i,
  input  logic                mon_clr_i,
  output pma_pkg::pma_cnt_t   mon_count_o
);

  import pma_pkg::*;

  pma_addr_t [`PMA_NUM_REGIONS-1:0] region_base;
  pma_addr_t [`PMA_NUM_REGIONS-1:0] region_limit;
  pma_attr_t [`PMA_NUM_REGIONS-1:0] region_attr;

  pma_list_t match_list;
  logic      have_match;
  pma_idx_t  match_idx;
  pma_attr_t match_attr;
  logic      stage_allow;
  logic      stage_misaligned;

  pma_region_regs u_regs (
    .clk_ungated    (clk_ungated),
    .rst_n          (rst_n),
    .cfg_we_i       (cfg_we_i),
    .cfg_region_i   (cfg_region_i),
    .cfg_field_i    (cfg_field_i),
    .cfg_wdata_i    (cfg_wdata_i),
    .cfg_rdata_o    (cfg_rdata_o),
    .region_base_o  (region_base),
    .region_limit_o (region_limit),
    .region_attr_o  (region_attr)
  );

  pma_match u_match (
    .clk_ungated    (clk_ungated),
    .trans_addr_i   (trans_addr_i),
    .region_base_i  (region_base),
    .region_limit_i (region_limit),
    .region_attr_i  (region_attr),
    .match_list_o   (match_list),
    .have_match_o   (have_match),
    .match_idx_o    (match_idx),
    .match_attr_o   (match_attr)
  );

  pma_checker u_checker (
    .clk_ungated        (clk_ungated),
    .rst_n              (rst_n),
    .trans_valid_i      (trans_valid_i),
    .trans_addr_i       (trans_addr_i),
    .trans_kind_i       (trans_kind_i),
    .trans_size_i       (trans_size_i),
    .have_match_i       (have_match),
    .match_idx_i        (match_idx),
    .match_attr_i       (match_attr),
    .resp_valid_o       (resp_valid_o),
    .resp_allow_o       (resp_allow_o),
    .resp_misaligned_o  (resp_misaligned_o),
    .resp_have_match_o  (resp_have_match_o),
    .resp_attr_o        (resp_attr_o),
    .resp_match_idx_o   (resp_match_idx_o),
    .stage_allow_o      (stage_allow),
    .stage_misaligned_o (stage_misaligned)
  );

  // Monitor samples the same stage-0 values the checker registers
  pma_event_monitor u_monitor (
    .clk_ungated   (clk_ungated),
    .rst_n         (rst_n),
    .trans_valid_i (trans_valid_i),
    .match_list_i  (match_list),
    .match_attr_i  (match_attr),
    .have_match_i  (have_match),
    .allow_i       (stage_allow),
    .misaligned_i  (stage_misaligned),
    .mon_sel_i     (mon_sel_i),
    .mon_clr_i     (mon_clr_i),
    .mon_count_o   (mon_count_o)
  );

endmodule

// File: design/pma_event_monitor.sv
// Saturating event counters over the stage-0 decision, with selectable readback and clear
`timescale 1ns/1ns

module pma_event_monitor (
  input  logic                clk_ungated,
  input  logic                rst_n,
  input  logic                trans_valid_i,
  input  pma_pkg::pma_list_t  match_list_i,
  input  pma_pkg::pma_attr_t  match_attr_i,
  input  logic                have_match_i,
  input  logic                allow_i,
  input  logic                misaligned_i,
  input  pma_pkg::pma_event_e mon_sel_i,
  input  logic                mon_clr_i,
  output pma_pkg::pma_cnt_t   mon_count_o
);

  import pma_pkg::*;

  localparam int EV_NUM = 5;

  logic [EV_NUM-1:0] ev;
  pma_cnt_t          cnt_q [EV_NUM];

  // Event bits line up with the selector encoding
  always_comb begin
    ev           = '0;
    ev[ACCESS]   = trans_valid_i;
    ev[MULTI]    = trans_valid_i && ($countones(match_list_i) >= 2);
    ev[MISALIGN] = trans_valid_i && misaligned_i;
    ev[DENY]     = trans_valid_i && !allow_i;
    ev[IO]       = trans_valid_i && have_match_i && !match_attr_i[2];
  end

  always_ff @(posedge clk_ungated or negedge rst_n) begin
    if (!rst_n) begin
      for (int e = 0; e < EV_NUM; e++) begin
        cnt_q[e] <= '0;
      end
    end else begin
      for (int e = 0; e < EV_NUM; e++) begin
        // Clear wins over a strobe in the same cycle
        if (mon_clr_i) begin
          cnt_q[e] <= '0;
        end else if (ev[e] && (cnt_q[e] != '1)) begin
          cnt_q[e] <= cnt_q[e] + 1'b1;
        end
      end
    end
  end

  always_comb begin
    if (int'(mon_sel_i) < EV_NUM) begin
      mon_count_o = cnt_q[mon_sel_i];
    end else begin
      mon_count_o = '0;
    end
  end

  // Counts only move down through a clear
  for (genvar g = 0; g < EV_NUM; g++) begin : g_mono
    a_no_decrease: assert property (
      @(posedge clk_ungated) disable iff (!rst_n)
      !mon_clr_i |=> (cnt_q[g] >= $past(cnt_q[g]))
    );
  end

endmodule

// File: design/pma_checker.sv
// Allow decision and misalignment check, registered into a one-cycle response
`timescale 1ns/1ns

module pma_checker (
  input  logic               clk_ungated,
  input  logic               rst_n,
  input  logic               trans_valid_i,
  input  pma_pkg::pma_addr_t trans_addr_i,
  input  pma_pkg::pma_kind_e trans_kind_i,
  input  pma_pkg::pma_size_e trans_size_i,
  input  logic               have_match_i,
  input  pma_pkg::pma_idx_t  match_idx_i,
  input  pma_pkg::pma_attr_t match_attr_i,
  output logic               resp_valid_o,
  output logic               resp_allow_o,
  output logic               resp_misaligned_o,
  output logic               resp_have_match_o,
  output pma_pkg::pma_attr_t resp_attr_o,
  output pma_pkg::pma_idx_t  resp_match_idx_o,
  output logic               stage_allow_o,
  output logic               stage_misaligned_o
);

  import pma_pkg::*;

  logic is_exec;
  logic is_main;

  assign is_exec = (trans_kind_i == EXEC);
  assign is_main = match_attr_i[2];

  always_comb begin
    case (trans_size_i)
      HALF:    stage_misaligned_o = trans_addr_i[0];
      WORD:    stage_misaligned_o = |trans_addr_i[1:0];
      default: stage_misaligned_o = 1'b0;
    endcase
  end

  // I/O regions take only aligned data accesses, fetches must be aligned everywhere
  assign stage_allow_o = have_match_i
                         && !(!is_main && (is_exec || stage_misaligned_o))
                         && !(is_exec && stage_misaligned_o);

  always_ff @(posedge clk_ungated or negedge rst_n) begin
    if (!rst_n) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= trans_valid_i;
    end
  end

  // Payload follows the strobe, qualified by resp_valid_o
  always_ff @(posedge clk_ungated) begin
    if (trans_valid_i) begin
      resp_allow_o      <= stage_allow_o;
      resp_misaligned_o <= stage_misaligned_o;
      resp_have_match_o <= have_match_i;
      resp_attr_o       <= match_attr_i;
      resp_match_idx_o  <= match_idx_i;
    end
  end

  // An allowed fetch must come back with main set
  a_exec_needs_main: assert property (
    @(posedge clk_ungated) disable iff (!rst_n)
    (trans_valid_i && stage_allow_o && is_exec) |=> (resp_allow_o && resp_attr_o[2])
  );

endmodule

// File: design/pma_match.sv
// Parallel region compare with lowest-index priority, feeding the checker and the monitor
`timescale 1ns/1ns
`include "pma_defines.svh"

module pma_match (
  input  logic                                      clk_ungated,
  input  pma_pkg::pma_addr_t                        trans_addr_i,
  input  pma_pkg::pma_addr_t [`PMA_NUM_REGIONS-1:0] region_base_i,
  input  pma_pkg::pma_addr_t [`PMA_NUM_REGIONS-1:0] region_limit_i,
  input  pma_pkg::pma_attr_t [`PMA_NUM_REGIONS-1:0] region_attr_i,
  output pma_pkg::pma_list_t                        match_list_o,
  output logic                                      have_match_o,
  output pma_pkg::pma_idx_t                         match_idx_o,
  output pma_pkg::pma_attr_t                        match_attr_o
);

  import pma_pkg::*;

  pma_list_t hit;

  // Region r covers the half-open range [base, limit)
  always_comb begin
    for (int r = 0; r < `PMA_NUM_REGIONS; r++) begin
      hit[r] = (region_base_i[r] <= trans_addr_i) && (trans_addr_i < region_limit_i[r]);
    end
  end

  // Walk from the top down so the lowest matching index is written last
  always_comb begin
    have_match_o = 1'b0;
    match_idx_o  = '0;
    match_attr_o = '0;
    for (int r = `PMA_NUM_REGIONS - 1; r >= 0; r--) begin
      if (hit[r]) begin
        have_match_o = 1'b1;
        match_idx_o  = pma_idx_t'(r);
        match_attr_o = region_attr_i[r];
      end
    end
  end

  assign match_list_o = hit;

  // Priority select and match list must agree on whether anything hit
  a_have_match_list: assert property (
    @(posedge clk_ungated) have_match_o == (|match_list_o)
  );

endmodule

// File: design/pma_region_regs.sv
// Region configuration registers with field-selected writes and combinational readback
`timescale 1ns/1ns
`include "pma_defines.svh"

module pma_region_regs (
  input  logic                                      clk_ungated,
  input  logic                                      rst_n,
  input  logic                                      cfg_we_i,
  input  pma_pkg::pma_idx_t                         cfg_region_i,
  input  pma_pkg::pma_field_e                       cfg_field_i,
  input  pma_pkg::pma_addr_t                        cfg_wdata_i,
  output pma_pkg::pma_addr_t                        cfg_rdata_o,
  output pma_pkg::pma_addr_t [`PMA_NUM_REGIONS-1:0] region_base_o,
  output pma_pkg::pma_addr_t [`PMA_NUM_REGIONS-1:0] region_limit_o,
  output pma_pkg::pma_attr_t [`PMA_NUM_REGIONS-1:0] region_attr_o
);

  import pma_pkg::*;

  pma_addr_t [`PMA_NUM_REGIONS-1:0] base_q;
  pma_addr_t [`PMA_NUM_REGIONS-1:0] limit_q;
  pma_attr_t [`PMA_NUM_REGIONS-1:0] attr_q;

  // All regions come out of reset empty since base equals limit
  always_ff @(posedge clk_ungated or negedge rst_n) begin
    if (!rst_n) begin
      base_q  <= '0;
      limit_q <= '0;
      attr_q  <= '0;
    end else if (cfg_we_i) begin
      case (cfg_field_i)
        BASE:    base_q[cfg_region_i]  <= cfg_wdata_i;
        LIMIT:   limit_q[cfg_region_i] <= cfg_wdata_i;
        // Only main, bufferable and cacheable are kept
        ATTR:    attr_q[cfg_region_i]  <= cfg_wdata_i[2:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    case (cfg_field_i)
      BASE:    cfg_rdata_o = base_q[cfg_region_i];
      LIMIT:   cfg_rdata_o = limit_q[cfg_region_i];
      ATTR:    cfg_rdata_o = pma_addr_t'(attr_q[cfg_region_i]);
      default: cfg_rdata_o = '0;
    endcase
  end

  assign region_base_o  = base_q;
  assign region_limit_o = limit_q;
  assign region_attr_o  = attr_q;

  // A write must always name a known region
  a_we_region_known: assert property (
    @(posedge clk_ungated) disable iff (!rst_n)
    cfg_we_i |-> !$isunknown(cfg_region_i)
  );

endmodule

// File: design/pma_pkg.sv
// Shared types of the PMA checking unit, imported by every module of the design
`include "pma_defines.svh"

package pma_pkg;

  typedef logic [`PMA_ADDR_W-1:0]      pma_addr_t;
  typedef logic [`PMA_IDX_W-1:0]       pma_idx_t;
  typedef logic [`PMA_NUM_REGIONS-1:0] pma_list_t;
  typedef logic [`PMA_CNT_W-1:0]       pma_cnt_t;

  // Bit 2 main, bit 1 bufferable, bit 0 cacheable
  typedef logic [2:0] pma_attr_t;

  typedef enum logic [1:0] {
    LOAD  = 2'd0,
    STORE = 2'd1,
    EXEC  = 2'd2
  } pma_kind_e;

  typedef enum logic [1:0] {
    BYTE = 2'd0,
    HALF = 2'd1,
    WORD = 2'd2
  } pma_size_e;

  // Configuration field selector
  typedef enum logic [1:0] {
    BASE  = 2'd0,
    LIMIT = 2'd1,
    ATTR  = 2'd2
  } pma_field_e;

  // Monitor counter selector
  typedef enum logic [2:0] {
    ACCESS   = 3'd0,
    MULTI    = 3'd1,
    MISALIGN = 3'd2,
    DENY     = 3'd3,
    IO       = 3'd4
  } pma_event_e;

endpackage

// File: design/pma_defines.svh
// Sizing macros for the PMA checking unit, included by the package and by modules that scale
`ifndef PMA_DEFINES_SVH
`define PMA_DEFINES_SVH

// Number of configurable address regions
`define PMA_NUM_REGIONS 4

// Width of a region index, enough to address every region
`define PMA_IDX_W 2

// Byte address width on the bus side being checked
`define PMA_ADDR_W 32

// Width of each event monitor counter
`define PMA_CNT_W 16

`endif
